//--- hdl/gpio_pkg.sv
package gpio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Number of GPIO pads on the port
  localparam int GPIO_WIDTH     = 21;
  // APB byte address and data widths
  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;
  // Flops between the pad and the first use of its value
  localparam int SYNC_STAGES    = 2;

  // One bit per pin
  typedef logic [GPIO_WIDTH-1:0] gpio_vec_t;

  // Interrupt kind, built per pin from {kind_hi, kind_lo}
  typedef enum logic [1:0] {
    IRQ_RISE       = 2'd0,
    IRQ_FALL       = 2'd1,
    IRQ_LEVEL_LOW  = 2'd2,
    IRQ_LEVEL_HIGH = 2'd3
  } irq_kind_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, byte offsets
  ////////////////////////////////////////////////////////////////////////////

  // Direction, a 1 makes the pin an output
  localparam logic [APB_ADDR_WIDTH-1:0] REG_DIR         = 8'h00;
  // Output values
  localparam logic [APB_ADDR_WIDTH-1:0] REG_OUT         = 8'h04;
  // Synchronized pad inputs, read only
  localparam logic [APB_ADDR_WIDTH-1:0] REG_IN          = 8'h08;
  // Per pin interrupt enable
  localparam logic [APB_ADDR_WIDTH-1:0] REG_IRQ_EN      = 8'h0C;
  // Kind bit 0 and kind bit 1 of every pin
  localparam logic [APB_ADDR_WIDTH-1:0] REG_IRQ_KIND_LO = 8'h10;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_IRQ_KIND_HI = 8'h14;
  // Sticky status, write ones to clear
  localparam logic [APB_ADDR_WIDTH-1:0] REG_IRQ_STATUS  = 8'h18;

endpackage

//--- hdl/gpio_irq_if.sv
`timescale 1ns/1ps

// Configuration and status between the register block and the interrupt unit
// All signals are valid every cycle, there is no handshake
interface gpio_irq_if
  import gpio_pkg::*;
();

  // Per pin enable
  gpio_vec_t enable;
  // Kind bits, combined per pin as {kind_hi, kind_lo}
  gpio_vec_t kind_lo;
  gpio_vec_t kind_hi;
  // One cycle pulse on a status write, ones clear the matching bits
  gpio_vec_t clear;
  // Sticky status held in the interrupt unit
  gpio_vec_t status;

  // Register side
  modport regs_mp (
    output enable,
    output kind_lo,
    output kind_hi,
    output clear,
    input  status
  );

  // Interrupt unit side
  modport irq_mp (
    input  enable,
    input  kind_lo,
    input  kind_hi,
    input  clear,
    output status
  );

endinterface

//--- hdl/gpio_input_sync.sv
`timescale 1ns/1ps

// Pad input synchronizer
// The last stage also feeds a delayed copy used for edge detection
module gpio_input_sync
  import gpio_pkg::*;
(
  input  logic      s_clk,
  input  logic      rst_n_i,
  input  gpio_vec_t gpio_i,
  output gpio_vec_t sync_o,
  output gpio_vec_t sync_prev_o
);

  // Synchronizer chain, stage 0 samples the asynchronous pads
  gpio_vec_t sync_q [SYNC_STAGES];
  // One more cycle of history
  gpio_vec_t prev_q;

  always_ff @(posedge s_clk) begin
    if (!rst_n_i) begin
      for (int s = 0; s < SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
      prev_q <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      // Shift along the chain
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
      // Value seen one cycle before the current synchronized value
      prev_q <= sync_q[SYNC_STAGES-1];
    end
  end

  // Pad change appears here SYNC_STAGES cycles later
  assign sync_o      = sync_q[SYNC_STAGES-1];
  assign sync_prev_o = prev_q;

endmodule

//--- hdl/gpio_irq_unit.sv
`timescale 1ns/1ps

// Per pin interrupt detection with sticky status
module gpio_irq_unit
  import gpio_pkg::*;
(
  input  logic      s_clk,
  input  logic      rst_n_i,
  input  gpio_vec_t sync_i,
  input  gpio_vec_t sync_prev_i,
  gpio_irq_if.irq_mp irq,
  output logic      irq_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Event detection
  ////////////////////////////////////////////////////////////////////////////

  // Raw conditions for every pin
  gpio_vec_t rise;
  gpio_vec_t fall;
  // Event selected by each pin's kind, masked by its enable
  gpio_vec_t event_vec;
  gpio_vec_t status_q;

  // Edges come from the synchronized value and its delayed copy
  assign rise = sync_i & ~sync_prev_i;
  assign fall = ~sync_i & sync_prev_i;

  always_comb begin
    irq_kind_t kind;
    event_vec = '0;
    kind      = IRQ_RISE;
    for (int i = 0; i < GPIO_WIDTH; i++) begin
      kind = irq_kind_t'({irq.kind_hi[i], irq.kind_lo[i]});
      case (kind)
        IRQ_RISE:       event_vec[i] = rise[i];
        IRQ_FALL:       event_vec[i] = fall[i];
        // Level kinds fire every cycle the level holds
        IRQ_LEVEL_LOW:  event_vec[i] = ~sync_i[i];
        IRQ_LEVEL_HIGH: event_vec[i] = sync_i[i];
        default:        event_vec[i] = 1'b0;
      endcase
      // Disabled pins never fire
      event_vec[i] = event_vec[i] & irq.enable[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sticky status
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_clk) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      // Clear first, then set, so a new event wins over a clear
      status_q <= (status_q & ~irq.clear) | event_vec;
    end
  end

  assign irq.status = status_q;

  // Combined interrupt line
  assign irq_o = |status_q;

endmodule

//--- hdl/gpio_apb_regs.sv
`timescale 1ns/1ps

// APB slave with the GPIO configuration registers
// Pad outputs come straight from the direction and output registers
module gpio_apb_regs
  import gpio_pkg::*;
(
  input  logic                      s_clk,
  input  logic                      rst_n_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  input  gpio_vec_t                 sync_i,
  gpio_irq_if.regs_mp               irq,
  output gpio_vec_t                 gpio_o,
  output gpio_vec_t                 gpio_oe_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // Access cycle of a transfer
  logic      access;
  // Offset maps to a register
  logic      addr_hit;
  // Transfer gets an error response
  logic      bad_xfer;
  // Write that updates state
  logic      wr_en;
  // Register value addressed by paddr_i
  gpio_vec_t rd_val;
  // Write data cut to pin width
  gpio_vec_t wdata;

  // Configuration registers
  gpio_vec_t dir_q;
  gpio_vec_t out_q;
  gpio_vec_t irq_en_q;
  gpio_vec_t kind_lo_q;
  gpio_vec_t kind_hi_q;

  assign access = psel_i & penable_i;
  assign wdata  = pwdata_i[GPIO_WIDTH-1:0];

  always_comb begin
    addr_hit = 1'b1;
    rd_val   = '0;
    case (paddr_i)
      REG_DIR:         rd_val = dir_q;
      REG_OUT:         rd_val = out_q;
      REG_IN:          rd_val = sync_i;
      REG_IRQ_EN:      rd_val = irq_en_q;
      REG_IRQ_KIND_LO: rd_val = kind_lo_q;
      REG_IRQ_KIND_HI: rd_val = kind_hi_q;
      REG_IRQ_STATUS:  rd_val = irq.status;
      default:         addr_hit = 1'b0;
    endcase
  end

  // Unmapped offsets and writes to the input register are errors
  assign bad_xfer = ~addr_hit | (pwrite_i & (paddr_i == REG_IN));
  // Error transfers change nothing
  assign wr_en    = access & pwrite_i & ~bad_xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // Zero wait states, every access cycle completes
  assign pready_o  = 1'b1;
  assign pslverr_o = access & bad_xfer;
  // Read data only during a read access, upper bits are zero
  assign prdata_o  = (access & ~pwrite_i)
                   ? {{(APB_DATA_WIDTH-GPIO_WIDTH){1'b0}}, rd_val}
                   : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  // Writes land at the edge that ends the access cycle
  always_ff @(posedge s_clk) begin
    if (!rst_n_i) begin
      dir_q     <= '0;
      out_q     <= '0;
      irq_en_q  <= '0;
      kind_lo_q <= '0;
      kind_hi_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_DIR:         dir_q     <= wdata;
        REG_OUT:         out_q     <= wdata;
        REG_IRQ_EN:      irq_en_q  <= wdata;
        REG_IRQ_KIND_LO: kind_lo_q <= wdata;
        REG_IRQ_KIND_HI: kind_hi_q <= wdata;
        default: ;
      endcase
    end
  end

  // Status clear pulse, lasts exactly the access cycle
  assign irq.clear   = (wr_en && paddr_i == REG_IRQ_STATUS) ? wdata : '0;
  assign irq.enable  = irq_en_q;
  assign irq.kind_lo = kind_lo_q;
  assign irq.kind_hi = kind_hi_q;

  // Pad drive
  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;

endmodule

//--- hdl/apb_gpio_top.sv
`timescale 1ns/1ps

// 21 pin APB GPIO with per pin interrupts
module apb_gpio_top
  import gpio_pkg::*;
(
  input  logic                      s_clk,
  input  logic                      rst_n_i,
  // APB slave
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // Pads
  input  gpio_vec_t                 gpio_i,
  output gpio_vec_t                 gpio_o,
  output gpio_vec_t                 gpio_oe_o,
  // Combined interrupt
  output logic                      irq_o
);

  // Synchronized pads and their delayed copy
  gpio_vec_t sync;
  gpio_vec_t sync_prev;

  // Interrupt configuration and status
  gpio_irq_if irq_bus ();

  gpio_input_sync u_input_sync (
    .s_clk       (s_clk),
    .rst_n_i     (rst_n_i),
    .gpio_i      (gpio_i),
    .sync_o      (sync),
    .sync_prev_o (sync_prev)
  );

  gpio_apb_regs u_apb_regs (
    .s_clk     (s_clk),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .sync_i    (sync),
    .irq       (irq_bus.regs_mp),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  gpio_irq_unit u_irq_unit (
    .s_clk       (s_clk),
    .rst_n_i     (rst_n_i),
    .sync_i      (sync),
    .sync_prev_i (sync_prev),
    .irq         (irq_bus.irq_mp),
    .irq_o       (irq_o)
  );

endmodule

//--- testbench/gpio_checker.sv
`timescale 1ns/1ps

// Watches the DUT ports and compares them with the expected values
// A check is taken at the rising edge while check_i is high
module gpio_checker
  import gpio_pkg::*;
(
  input  logic                      s_clk,
  input  logic                      check_i,
  // High for a check after a pad wait, low for an APB access cycle
  input  logic                      pad_check_i,
  input  logic [127:0]              name_i,
  input  logic [APB_DATA_WIDTH-1:0] exp_rdata_i,
  input  logic                      exp_err_i,
  input  logic                      exp_irq_i,
  input  gpio_vec_t                 exp_gpio_i,
  input  gpio_vec_t                 exp_oe_i,
  // DUT ports
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_DATA_WIDTH-1:0] prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i,
  input  gpio_vec_t                 gpio_i,
  input  gpio_vec_t                 gpio_oe_i,
  input  logic                      irq_i,
  output int                        err_count_o
);

  int errs = 0;

  assign err_count_o = errs;

  task automatic compare_field(input string field, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("mismatch %0s %0s: expected %h actual %h", name_i, field, exp_val, act_val);
      errs++;
    end
  endtask

  always @(posedge s_clk) begin
    // Zero wait states, so every access cycle must complete
    if (psel_i && penable_i && !pready_i) begin
      $display("Error in %0s: pready was low in an access cycle", name_i);
      errs++;
    end
    if (check_i) begin
      if (!pad_check_i) begin
        if (!pwrite_i) begin
          compare_field("prdata", exp_rdata_i, prdata_i);
        end
        compare_field("pslverr", 32'(exp_err_i), 32'(pslverr_i));
      end
      compare_field("irq", 32'(exp_irq_i), 32'(irq_i));
      compare_field("gpio_o", 32'(exp_gpio_i), 32'(gpio_i));
      compare_field("gpio_oe", 32'(exp_oe_i), 32'(gpio_oe_i));
    end
  end

endmodule

//--- testbench/tb_apb_gpio.sv
`timescale 1ns/1ps

module tb_apb_gpio
  import gpio_pkg::*;
();

  localparam logic [1:0] OP_WR  = 2'd0;
  localparam logic [1:0] OP_RD  = 2'd1;
  localparam logic [1:0] OP_PAD = 2'd2;

  // One stimulus step with its expected response
  typedef struct packed {
    logic [127:0] name;
    logic [1:0]   op;
    logic [7:0]   off;
    logic [31:0]  wdata;
    gpio_vec_t    pad;
    logic [31:0]  rdata;
    logic         err;
    logic         irq;
  } entry_t;

  logic s_clk = 1'b0;
  logic rst_n_i;
  logic psel, penable, pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata, prdata;
  logic pready, pslverr, irq;
  gpio_vec_t gpio_in, gpio_out, gpio_oe;
  // Checker strobe and expected values
  logic chk, chk_pad, exp_err, exp_irq;
  logic [127:0] cur_name;
  logic [31:0] exp_rdata;
  gpio_vec_t exp_gpio, exp_oe;
  int err_count;

  entry_t tbl [64];
  int n_ent = 0;
  logic [31:0] lfsr = 32'h339b;

  always #50 s_clk = ~s_clk;

  apb_gpio_top UUT (
    .s_clk(s_clk), .rst_n_i(rst_n_i), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
    .pready_o(pready), .pslverr_o(pslverr), .gpio_i(gpio_in), .gpio_o(gpio_out),
    .gpio_oe_o(gpio_oe), .irq_o(irq)
  );

  gpio_checker u_checker (
    .s_clk(s_clk), .check_i(chk), .pad_check_i(chk_pad), .name_i(cur_name),
    .exp_rdata_i(exp_rdata), .exp_err_i(exp_err), .exp_irq_i(exp_irq),
    .exp_gpio_i(exp_gpio), .exp_oe_i(exp_oe), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr),
    .gpio_i(gpio_out), .gpio_oe_i(gpio_oe), .irq_i(irq), .err_count_o(err_count)
  );

  // Galois LFSR, taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per pin bit
  task automatic draw_pins(output gpio_vec_t v);
    for (int b = 0; b < GPIO_WIDTH; b++) begin
      lfsr = lfsr_next(lfsr);
      v[b] = lfsr[0];
    end
  endtask

  // Val is write data, expected read data or pad value, by operation
  task automatic add_entry(input logic [127:0] name, input logic [1:0] op,
                           input logic [7:0] off, input logic [31:0] val,
                           input logic err, input logic irq_exp);
    tbl[n_ent] = '{name, op, off, val, val[GPIO_WIDTH-1:0], val, err, irq_exp};
    n_ent++;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Watchdog, 8 cycles per entry, doubled
  //////////////////////////////////////////////////////////////////////////

  initial begin
    // Table is complete once reset is released
    wait (rst_n_i === 1'b1);
    #(n_ent * 8 * 100 * 2);
    $display("Timeout: the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  initial begin
    gpio_vec_t r_dir, r_out, r_in, m_dir, m_out;
    entry_t e;
    rst_n_i = 1'b0;
    {psel, penable, pwrite, chk, chk_pad, exp_err, exp_irq} = '0;
    {paddr, pwdata, exp_rdata, cur_name} = '0;
    {gpio_in, exp_gpio, exp_oe, m_dir, m_out} = '0;
    draw_pins(r_dir);
    draw_pins(r_out);
    draw_pins(r_in);

    // Reset state, every register reads zero
    for (int a = 0; a <= 24; a += 4) begin
      add_entry("reset_read", OP_RD, 8'(a), 32'h0, 1'b0, 1'b0);
    end
    // Output drive with random data, then error transfers
    add_entry("wr_dir", OP_WR, REG_DIR, 32'(r_dir), 1'b0, 1'b0);
    add_entry("wr_out", OP_WR, REG_OUT, 32'(r_out), 1'b0, 1'b0);
    add_entry("rd_dir", OP_RD, REG_DIR, 32'(r_dir), 1'b0, 1'b0);
    add_entry("rd_out", OP_RD, REG_OUT, 32'(r_out), 1'b0, 1'b0);
    add_entry("wr_in_err", OP_WR, REG_IN, 32'h1F_FFFF, 1'b1, 1'b0);
    add_entry("wr_unmapped", OP_WR, 8'h1C, 32'h1F_FFFF, 1'b1, 1'b0);
    add_entry("rd_unmapped", OP_RD, 8'h40, 32'h0, 1'b1, 1'b0);
    add_entry("rd_dir_kept", OP_RD, REG_DIR, 32'(r_dir), 1'b0, 1'b0);
    add_entry("rd_out_kept", OP_RD, REG_OUT, 32'(r_out), 1'b0, 1'b0);
    // Input path
    add_entry("pad_rand", OP_PAD, 8'h0, 32'(r_in), 1'b0, 1'b0);
    add_entry("rd_in_rand", OP_RD, REG_IN, 32'(r_in), 1'b0, 1'b0);
    add_entry("pad_pin2", OP_PAD, 8'h0, 32'h04, 1'b0, 1'b0);
    add_entry("rd_in_pin2", OP_RD, REG_IN, 32'h04, 1'b0, 1'b0);
    // Pin 0 rise, 1 fall, 2 level low, 3 level high, 4 level high disabled
    add_entry("wr_kind_lo", OP_WR, REG_IRQ_KIND_LO, 32'h1A, 1'b0, 1'b0);
    add_entry("wr_kind_hi", OP_WR, REG_IRQ_KIND_HI, 32'h1C, 1'b0, 1'b0);
    add_entry("wr_irq_en", OP_WR, REG_IRQ_EN, 32'h0F, 1'b0, 1'b0);
    // Edge kinds
    add_entry("rise_pin0", OP_PAD, 8'h0, 32'h05, 1'b0, 1'b1);
    add_entry("rd_st_rise", OP_RD, REG_IRQ_STATUS, 32'h01, 1'b0, 1'b1);
    add_entry("clr_rise", OP_WR, REG_IRQ_STATUS, 32'h01, 1'b0, 1'b1);
    add_entry("rd_st_clr0", OP_RD, REG_IRQ_STATUS, 32'h00, 1'b0, 1'b0);
    add_entry("fall_pin0_none", OP_PAD, 8'h0, 32'h04, 1'b0, 1'b0);
    add_entry("rise_pin1_none", OP_PAD, 8'h0, 32'h06, 1'b0, 1'b0);
    add_entry("fall_pin1", OP_PAD, 8'h0, 32'h04, 1'b0, 1'b1);
    add_entry("rd_st_fall", OP_RD, REG_IRQ_STATUS, 32'h02, 1'b0, 1'b1);
    add_entry("clr_fall", OP_WR, REG_IRQ_STATUS, 32'h02, 1'b0, 1'b1);
    add_entry("rd_st_clr1", OP_RD, REG_IRQ_STATUS, 32'h00, 1'b0, 1'b0);
    // Level kinds, status comes back while the level holds
    add_entry("low_pin2", OP_PAD, 8'h0, 32'h00, 1'b0, 1'b1);
    add_entry("rd_st_low", OP_RD, REG_IRQ_STATUS, 32'h04, 1'b0, 1'b1);
    add_entry("clr_low_held", OP_WR, REG_IRQ_STATUS, 32'h04, 1'b0, 1'b1);
    add_entry("rd_st_low_again", OP_RD, REG_IRQ_STATUS, 32'h04, 1'b0, 1'b1);
    add_entry("low_removed", OP_PAD, 8'h0, 32'h04, 1'b0, 1'b1);
    add_entry("clr_low", OP_WR, REG_IRQ_STATUS, 32'h04, 1'b0, 1'b1);
    add_entry("rd_st_clr2", OP_RD, REG_IRQ_STATUS, 32'h00, 1'b0, 1'b0);
    add_entry("high_pin3", OP_PAD, 8'h0, 32'h0C, 1'b0, 1'b1);
    add_entry("rd_st_high", OP_RD, REG_IRQ_STATUS, 32'h08, 1'b0, 1'b1);
    add_entry("clr_high_held", OP_WR, REG_IRQ_STATUS, 32'h08, 1'b0, 1'b1);
    add_entry("rd_st_hi_again", OP_RD, REG_IRQ_STATUS, 32'h08, 1'b0, 1'b1);
    add_entry("high_removed", OP_PAD, 8'h0, 32'h04, 1'b0, 1'b1);
    add_entry("clr_high", OP_WR, REG_IRQ_STATUS, 32'h08, 1'b0, 1'b1);
    add_entry("rd_st_clr3", OP_RD, REG_IRQ_STATUS, 32'h00, 1'b0, 1'b0);
    // Disabled pins toggle with no effect on status
    add_entry("disabled_up", OP_PAD, 8'h0, 32'h1F_FFF4, 1'b0, 1'b0);
    add_entry("rd_in_upper", OP_RD, REG_IN, 32'h1F_FFF4, 1'b0, 1'b0);
    add_entry("rd_st_dis_up", OP_RD, REG_IRQ_STATUS, 32'h00, 1'b0, 1'b0);
    add_entry("disabled_down", OP_PAD, 8'h0, 32'h04, 1'b0, 1'b0);
    add_entry("rd_st_dis_down", OP_RD, REG_IRQ_STATUS, 32'h00, 1'b0, 1'b0);

    // Reset held over two rising edges
    repeat (2) @(posedge s_clk);
    @(negedge s_clk);
    rst_n_i = 1'b1;

    for (int i = 0; i < n_ent; i++) begin
      e = tbl[i];
      @(negedge s_clk);
      chk = 1'b0;
      if (e.op == OP_PAD) begin
        psel    = 1'b0;
        penable = 1'b0;
        gpio_in = e.pad;
        // Check lands on the fourth edge after the pad change
        repeat (3) @(negedge s_clk);
      end else begin
        // Setup cycle, then access cycle
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = (e.op == OP_WR);
        paddr   = e.off;
        pwdata  = e.wdata;
        @(negedge s_clk);
        penable = 1'b1;
      end
      cur_name  = e.name;
      exp_rdata = e.rdata;
      exp_err   = e.err;
      exp_irq   = e.irq;
      // Pad drive seen before this write lands
      exp_gpio  = m_out;
      exp_oe    = m_dir;
      chk_pad   = (e.op == OP_PAD);
      chk       = 1'b1;
      if (e.op == OP_WR && !e.err && e.off == REG_DIR) begin
        m_dir = e.wdata[GPIO_WIDTH-1:0];
      end
      if (e.op == OP_WR && !e.err && e.off == REG_OUT) begin
        m_out = e.wdata[GPIO_WIDTH-1:0];
      end
    end
    @(negedge s_clk);
    chk     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    @(negedge s_clk);

    $display("Run complete: %0d entries, %0d errors", n_ent, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/gpio_pkg.sv
hdl/gpio_irq_if.sv
hdl/gpio_input_sync.sv
hdl/gpio_irq_unit.sv
hdl/gpio_apb_regs.sv
hdl/apb_gpio_top.sv
testbench/gpio_checker.sv
testbench/tb_apb_gpio.sv

//--- Makefile
TOP := tb_apb_gpio

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
